//--- hw/pulser_pkg.sv
`default_nettype none

package pulser_pkg;

    // field width shared by pulse count and half-period
    localparam int CNT_W = 7;

    // opcode in bit 7 of a command byte
    localparam logic OP_COUNT  = 1'b0;
    localparam logic OP_PERIOD = 1'b1;

    // register contents after reset
    localparam logic [CNT_W-1:0] DEFAULT_COUNT = CNT_W'(4);
    localparam logic [CNT_W-1:0] DEFAULT_HALF  = CNT_W'(8);    // clock cycles

    // one command byte, read either as a count or as a period
    typedef union packed {
        struct packed {
            logic             op;
            logic [CNT_W-1:0] count;
        } cnt;
        struct packed {
            logic             op;
            logic [CNT_W-1:0] half;
        } per;
    } cmd_word_u;

endpackage

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
#(
    parameter int CLKS_PER_BIT = 13021
)
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_byte_valid
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    localparam logic [CW-1:0] FULL_TICK = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] MID_TICK  = CW'(CLKS_PER_BIT / 2 - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic          rx_meta;
    logic          rx_sync;
    logic [1:0]    state;
    logic [CW-1:0] tick;
    logic [2:0]    bit_idx;
    logic          shift_en;

    // line idles high, so the synchroniser resets to 1
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    assign shift_en = (state == S_DATA) && (tick == FULL_TICK);

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_IDLE;
            tick         <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    tick <= '0;
                    if (!rx_sync) state <= S_START;
                end
                S_START: begin
                    if (tick == MID_TICK) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;    // glitch, not a start bit
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                S_DATA: begin
                    if (tick == FULL_TICK) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin    // stop bit
                    if (tick == FULL_TICK) begin
                        o_byte_valid <= rx_sync;    // framing error drops the byte
                        state        <= S_IDLE;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge i_clock) begin
        if (shift_en) o_byte <= {rx_sync, o_byte[7:1]};
    end

endmodule

`default_nettype wire

//--- hw/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
#(
    parameter int DEAD_CYCLES = 2
)
(
    input  logic                         i_clock,
    input  logic                         i_rst_n,
    input  logic [7:0]                   i_byte,
    input  logic                         i_byte_valid,
    output logic [pulser_pkg::CNT_W-1:0] o_pulse_count,
    output logic [pulser_pkg::CNT_W-1:0] o_half_period
);

    import pulser_pkg::*;

    // a phase must keep at least one driven cycle after dead time
    localparam logic [CNT_W-1:0] DEAD_LIM = CNT_W'(DEAD_CYCLES);

    cmd_word_u cmd;
    logic      count_ok;
    logic      period_ok;

    assign cmd = cmd_word_u'(i_byte);

    assign count_ok  = (cmd.cnt.count != '0);
    assign period_ok = (cmd.per.half > DEAD_LIM);    // also rules out zero

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pulse_count <= DEFAULT_COUNT;
            o_half_period <= DEFAULT_HALF;
        end else if (i_byte_valid) begin
            case (cmd.cnt.op)
                OP_COUNT: begin
                    if (count_ok) o_pulse_count <= cmd.cnt.count;
                end
                OP_PERIOD: begin
                    if (period_ok) o_half_period <= cmd.per.half;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer
(
    input  logic                         i_clock,
    input  logic                         i_rst_n,
    input  logic                         i_sample,
    input  logic                         i_gate,
    input  logic                         i_adc_init_done,
    input  logic [pulser_pkg::CNT_W-1:0] i_pulse_count,
    input  logic [pulser_pkg::CNT_W-1:0] i_half_period,
    output logic                         o_phase_valid,
    output logic                         o_phase_high,
    output logic                         o_phase_start,
    output logic                         o_led_armed
);

    import pulser_pkg::*;

    // bit 0 sample, bit 1 gate, bit 2 adc init done
    logic [2:0]       async_meta;
    logic [2:0]       async_sync;
    logic             sample_d;
    logic             sample_rise;
    logic             qualified;
    logic             trigger;
    logic             phase_end;
    logic [CNT_W-1:0] half_q;
    logic [CNT_W-1:0] pulses_left;
    logic [CNT_W-1:0] cyc_cnt;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            async_meta  <= '0;
            async_sync  <= '0;
            sample_d    <= 1'b0;
            sample_rise <= 1'b0;
            o_led_armed <= 1'b0;
        end else begin
            async_meta  <= {i_adc_init_done, i_gate, i_sample};
            async_sync  <= async_meta;
            sample_d    <= async_sync[0];
            sample_rise <= async_sync[0] & ~sample_d;    // registered edge
            o_led_armed <= qualified;
        end
    end

    assign qualified = async_sync[1] & async_sync[2];
    assign trigger   = sample_rise & qualified & ~o_phase_valid;    // busy drops it
    assign phase_end = (cyc_cnt == half_q - 1'b1);

    always_ff @(posedge i_clock) begin
        if (trigger) half_q <= i_half_period;
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_phase_valid <= 1'b0;
            o_phase_high  <= 1'b0;
            o_phase_start <= 1'b0;
            pulses_left   <= '0;
            cyc_cnt       <= '0;
        end else begin
            o_phase_start <= 1'b0;
            if (trigger) begin
                o_phase_valid <= 1'b1;
                o_phase_high  <= 1'b1;
                o_phase_start <= 1'b1;
                pulses_left   <= i_pulse_count;
                cyc_cnt       <= '0;
            end else if (o_phase_valid) begin
                if (phase_end) begin
                    cyc_cnt <= '0;
                    if (o_phase_high) begin
                        o_phase_high  <= 1'b0;
                        o_phase_start <= 1'b1;
                    end else if (pulses_left == CNT_W'(1)) begin
                        o_phase_valid <= 1'b0;    // last low phase done
                    end else begin
                        pulses_left   <= pulses_left - 1'b1;
                        o_phase_high  <= 1'b1;
                        o_phase_start <= 1'b1;
                    end
                end else begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pulse_driver.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_driver
#(
    parameter int DEAD_CYCLES = 2
)
(
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic i_phase_valid,
    input  logic i_phase_high,
    input  logic i_phase_start,
    output logic o_tx_ch1_h,
    output logic o_tx_ch1_l,
    output logic o_led_fire
);

    // one extra bit so the counter can hold DEAD_CYCLES even when it is 0
    localparam int DW = $clog2(DEAD_CYCLES + 2);

    localparam logic [DW-1:0] DEAD_MAX = DW'(DEAD_CYCLES);

    logic [DW-1:0] dead_cnt;
    logic [DW-1:0] elapsed;
    logic          leg_en;

    // cycles since the current phase began, saturating at DEAD_MAX
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dead_cnt <= '0;
        end else if (i_phase_start) begin
            dead_cnt <= DW'(1);
        end else if (dead_cnt < DEAD_MAX) begin
            dead_cnt <= dead_cnt + 1'b1;
        end
    end

    assign elapsed = i_phase_start ? '0 : dead_cnt;
    assign leg_en  = i_phase_valid & (elapsed >= DEAD_MAX);

    // both legs share leg_en but split on i_phase_high, so never both on
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx_ch1_h <= 1'b0;
            o_tx_ch1_l <= 1'b0;
            o_led_fire <= 1'b0;
        end else begin
            o_tx_ch1_h <= leg_en &  i_phase_high;
            o_tx_ch1_l <= leg_en & ~i_phase_high;
            o_led_fire <= i_phase_valid;
        end
    end

endmodule

`default_nettype wire

//--- hw/pulser_top.sv
`timescale 1ns/1ps
`default_nettype none

module pulser_top
#(
    parameter int CLKS_PER_BIT = 13021,    // 125 MHz at 9600 baud
    parameter int DEAD_CYCLES  = 2
)
(
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic i_rx,
    input  logic i_sample,
    input  logic i_gate,
    input  logic i_adc_init_done,
    output logic o_tx_ch1_h,
    output logic o_tx_ch1_l,
    output logic o_led0_g,    // armed
    output logic o_led1_r     // firing
);

    import pulser_pkg::*;

    logic [7:0]       rx_byte;
    logic             rx_byte_valid;
    logic [CNT_W-1:0] pulse_count;
    logic [CNT_W-1:0] half_period;
    logic             phase_valid;
    logic             phase_high;
    logic             phase_start;

    uart_rx #
    (
        .CLKS_PER_BIT    ( CLKS_PER_BIT    )
    )
    u_uart_rx
    (
        .i_clock         ( i_clock         ),
        .i_rst_n         ( i_rst_n         ),
        .i_rx            ( i_rx            ),
        .o_byte          ( rx_byte         ),
        .o_byte_valid    ( rx_byte_valid   )
    );

    cmd_decoder #
    (
        .DEAD_CYCLES     ( DEAD_CYCLES     )
    )
    u_cmd_decoder
    (
        .i_clock         ( i_clock         ),
        .i_rst_n         ( i_rst_n         ),
        .i_byte          ( rx_byte         ),
        .i_byte_valid    ( rx_byte_valid   ),
        .o_pulse_count   ( pulse_count     ),
        .o_half_period   ( half_period     )
    );

    burst_sequencer
    u_burst_sequencer
    (
        .i_clock         ( i_clock         ),
        .i_rst_n         ( i_rst_n         ),
        .i_sample        ( i_sample        ),
        .i_gate          ( i_gate          ),
        .i_adc_init_done ( i_adc_init_done ),
        .i_pulse_count   ( pulse_count     ),
        .i_half_period   ( half_period     ),
        .o_phase_valid   ( phase_valid     ),
        .o_phase_high    ( phase_high      ),
        .o_phase_start   ( phase_start     ),
        .o_led_armed     ( o_led0_g        )
    );

    pulse_driver #
    (
        .DEAD_CYCLES     ( DEAD_CYCLES     )
    )
    u_pulse_driver
    (
        .i_clock         ( i_clock         ),
        .i_rst_n         ( i_rst_n         ),
        .i_phase_valid   ( phase_valid     ),
        .i_phase_high    ( phase_high      ),
        .i_phase_start   ( phase_start     ),
        .o_tx_ch1_h      ( o_tx_ch1_h      ),
        .o_tx_ch1_l      ( o_tx_ch1_l      ),
        .o_led_fire      ( o_led1_r        )
    );

endmodule

`default_nettype wire

//--- sim/pulser_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pulser_tb;

    import pulser_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int DEAD_CYCLES  = 2;

    logic clk;
    logic i_rst_n;
    logic i_rx;
    logic i_sample;
    logic i_gate;
    logic i_adc_init_done;
    logic o_tx_ch1_h;
    logic o_tx_ch1_l;
    logic o_led0_g;
    logic o_led1_r;

    int errors;
    int leg_faults;
    int tests_run;
    int tests_bad;
    int h_rises;
    int l_rises;
    int exp_width;
    int exp_count;    // model of the decoder registers
    int exp_half;
    bit hung;

    pulser_top #(
        .CLKS_PER_BIT    ( CLKS_PER_BIT    ),
        .DEAD_CYCLES     ( DEAD_CYCLES     )
    ) pulser_top_i (
        .i_clock         ( clk             ),
        .i_rst_n         ( i_rst_n         ),
        .i_rx            ( i_rx            ),
        .i_sample        ( i_sample        ),
        .i_gate          ( i_gate          ),
        .i_adc_init_done ( i_adc_init_done ),
        .o_tx_ch1_h      ( o_tx_ch1_h      ),
        .o_tx_ch1_l      ( o_tx_ch1_l      ),
        .o_led0_g        ( o_led0_g        ),
        .o_led1_r        ( o_led1_r        )
    );

    always #2 clk = ~clk;

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic time_out(input string what);
        $display("timeout: %s", what);
        hung = 1'b1;
    endtask

    // start bit, eight data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            i_rx <= frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        idle(4);
    endtask

    task automatic send_cmd(input logic op, input int val);
        cmd_word_u w;
        if (op == OP_COUNT) begin
            w.cnt.op    = op;
            w.cnt.count = CNT_W'(val);
            if (val != 0) exp_count = val;
        end else begin
            w.per.op   = op;
            w.per.half = CNT_W'(val);
            if (val > DEAD_CYCLES) exp_half = val;    // phase must outlast dead time
        end
        send_byte(w);
    endtask

    task automatic watch_legs();
        logic prev_h;
        logic prev_l;
        int   h_run;
        int   l_run;
        prev_h = 1'b0;
        prev_l = 1'b0;
        h_run  = 0;
        l_run  = 0;
        forever begin
            @(negedge clk);
            assert (!(o_tx_ch1_h && o_tx_ch1_l)) else begin
                $display("ERR %0t: both legs high in the same cycle", $time);
                leg_faults++;
            end
            assert (o_led1_r || !(o_tx_ch1_h || o_tx_ch1_l)) else begin
                $display("ERR %0t: leg high while no burst runs", $time);
                leg_faults++;
            end
            if (o_tx_ch1_h) begin
                if (!prev_h) h_rises++;
                h_run = prev_h ? h_run + 1 : 1;
            end else if (prev_h) begin
                assert (h_run == exp_width) else begin
                    $display("ERR %0t: high leg width %0d, expected %0d", $time, h_run, exp_width);
                    errors++;
                end
            end
            if (o_tx_ch1_l) begin
                if (!prev_l) l_rises++;
                l_run = prev_l ? l_run + 1 : 1;
            end else if (prev_l) begin
                assert (l_run == exp_width) else begin
                    $display("ERR %0t: low leg width %0d, expected %0d", $time, l_run, exp_width);
                    errors++;
                end
            end
            prev_h = o_tx_ch1_h;
            prev_l = o_tx_ch1_l;
        end
    endtask

    // one burst with i_sample held high until it is over
    task automatic fire_and_check(input int c, input int h);
        int n;
        int limit;
        h_rises   = 0;
        l_rises   = 0;
        exp_width = h - DEAD_CYCLES;
        limit     = 2 * c * h + 40;
        @(posedge clk);
        i_sample <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_tx_ch1_h && n < 40);
        if (!o_tx_ch1_h) begin
            time_out("high leg never switched on after the trigger");
            return;
        end
        // dut first sees i_sample one edge after it is driven
        assert (n - 1 == 1 + 4 + DEAD_CYCLES) else begin
            $display("ERR %0t: first high leg after %0d cycles, expected %0d",
                     $time, n - 1, 1 + 4 + DEAD_CYCLES);
            errors++;
        end
        assert (o_led1_r) else begin
            $display("ERR %0t: firing led dark during the burst", $time);
            errors++;
        end
        while (o_led1_r && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (o_led1_r) begin
            time_out("firing led stayed on past the burst");
            return;
        end
        // led lit from drive edge 5 for 2*count*half cycles
        assert (n == 6 + 2 * c * h) else begin
            $display("ERR %0t: burst ended at cycle %0d, expected %0d", $time, n, 6 + 2 * c * h);
            errors++;
        end
        @(negedge clk);
        assert (h_rises == c && l_rises == c) else begin
            $display("ERR %0t: pulses h %0d l %0d, expected %0d", $time, h_rises, l_rises, c);
            errors++;
        end
        @(posedge clk);
        i_sample <= 1'b0;
        idle(6);
    endtask

    task automatic expect_quiet(input string why);
        int lit;
        h_rises = 0;
        l_rises = 0;
        lit     = 0;
        @(posedge clk);
        i_sample <= 1'b1;
        for (int n = 0; n < 40; n++) begin
            @(negedge clk);
            if (o_led1_r) lit++;
        end
        assert (lit == 0 && h_rises == 0 && l_rises == 0) else begin
            $display("ERR %0t: burst fired with %s", $time, why);
            errors++;
        end
        assert (!o_led0_g) else begin
            $display("ERR %0t: armed led lit with %s", $time, why);
            errors++;
        end
        @(posedge clk);
        i_sample <= 1'b0;
        idle(6);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_bad++;
            $display("%-20s: %0d error(s)", name, errors - err_before);
        end else begin
            $display("%-20s: ok", name);
        end
    endtask

    task automatic default_burst();
        int e0;
        e0 = errors;
        @(posedge clk);
        i_adc_init_done <= 1'b1;
        i_gate          <= 1'b1;
        idle(6);
        assert (o_led0_g) else begin
            $display("ERR %0t: armed led dark with gate and adc ready", $time);
            errors++;
        end
        fire_and_check(exp_count, exp_half);
        if (hung) return;
        end_test("default burst", e0);
    endtask

    task automatic configured_burst();
        int e0;
        e0 = errors;
        send_cmd(OP_COUNT, 3);
        send_cmd(OP_PERIOD, 6);
        fire_and_check(exp_count, exp_half);
        if (hung) return;
        end_test("configured burst", e0);
    endtask

    task automatic rejected_commands();
        int e0;
        e0 = errors;
        send_cmd(OP_COUNT, 0);
        send_cmd(OP_PERIOD, DEAD_CYCLES);
        fire_and_check(exp_count, exp_half);
        if (hung) return;
        end_test("rejected commands", e0);
    endtask

    task automatic trigger_qualification();
        int e0;
        int n;
        int lit;
        e0 = errors;
        @(posedge clk);
        i_gate <= 1'b0;
        idle(6);
        expect_quiet("gate low");
        @(posedge clk);
        i_gate          <= 1'b1;
        i_adc_init_done <= 1'b0;
        idle(6);
        expect_quiet("adc not ready");
        @(posedge clk);
        i_adc_init_done <= 1'b1;
        idle(6);
        h_rises   = 0;
        l_rises   = 0;
        exp_width = exp_half - DEAD_CYCLES;
        @(posedge clk);
        i_sample <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_led1_r && n < 40);
        if (!o_led1_r) begin
            time_out("firing led never lit for the retrigger burst");
            return;
        end
        @(posedge clk);
        i_sample <= 1'b0;
        idle(4);
        i_sample <= 1'b1;    // second edge while the burst runs
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (o_led1_r && n < 2 * exp_count * exp_half + 40);
        if (o_led1_r) begin
            time_out("firing led stayed on in the retrigger burst");
            return;
        end
        lit = 0;
        for (int k = 0; k < 30; k++) begin
            @(negedge clk);
            if (o_led1_r) lit++;
        end
        assert (h_rises == exp_count && l_rises == exp_count && lit == 0) else begin
            $display("ERR %0t: retrigger changed the burst, h %0d l %0d late %0d",
                     $time, h_rises, l_rises, lit);
            errors++;
        end
        @(posedge clk);
        i_sample <= 1'b0;
        idle(6);
        end_test("qualification", e0);
    endtask

    task automatic random_settings();
        int e0;
        int c;
        int h;
        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            c = 1 + int'($urandom % 6);
            h = DEAD_CYCLES + 1 + int'($urandom % 10);
            send_cmd(OP_COUNT, c);
            send_cmd(OP_PERIOD, h);
            fire_and_check(exp_count, exp_half);
            if (hung) return;
        end
        end_test("random settings", e0);
    endtask

    task automatic leg_safety_tally();
        int e0;
        e0 = errors;
        errors += leg_faults;    // gathered by the monitor over the whole run
        end_test("leg safety", e0);
    endtask

    initial begin
        clk             = 1'b0;
        i_rst_n         = 1'b0;
        i_rx            = 1'b1;
        i_sample        = 1'b0;
        i_gate          = 1'b0;
        i_adc_init_done = 1'b0;
        errors          = 0;
        leg_faults      = 0;
        tests_run       = 0;
        tests_bad       = 0;
        h_rises         = 0;
        l_rises         = 0;
        hung            = 1'b0;
        exp_count       = int'(DEFAULT_COUNT);
        exp_half        = int'(DEFAULT_HALF);
        exp_width       = exp_half - DEAD_CYCLES;
        void'($urandom(4188));
        idle(10);
        i_rst_n <= 1'b1;
        idle(2);
        fork
            watch_legs();
        join_none
        default_burst();
        if (!hung) configured_burst();
        if (!hung) rejected_commands();
        if (!hung) trigger_qualification();
        if (!hung) random_settings();
        if (!hung) leg_safety_tally();
        $display("tests run %0d, with errors %0d, total errors %0d",
                 tests_run, tests_bad, errors);
        if (!hung && errors == 0 && leg_faults == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/pulser_pkg.sv
hw/uart_rx.sv
hw/cmd_decoder.sv
hw/burst_sequencer.sv
hw/pulse_driver.sv
hw/pulser_top.sv
sim/pulser_tb.sv

//--- Makefile
# verilator build of the pulser testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pulser_tb -f sources.f
	@out="$$(./obj_dir/Vpulser_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
